//--- filelist.f
source/cpuPkg.sv
source/opcodeFlowLut.sv
source/ucodeRom.sv
source/ucodeSequencer.sv
source/cpuDatapath.sv
source/wbBusMaster.sv
source/cpuCore.sv
verif/cpuCoreTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module cpuCoreTb \
		-f filelist.f -o cpuCoreSim
	./obj_dir/cpuCoreSim

clean:
	rm -rf obj_dir

//--- verif/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;
	import cpuPkg::*;

	localparam int haltTimeout = 20000;
	localparam int quietCycles = 20;

	logic clock;
	logic arstN;
	wbReqT wbOut;
	wbRspT wbIn;
	logic halted;

	// Bus-side memory and the model's own copy
	logic [7:0] mem [0:65535];
	logic [7:0] refMem [0:65535];
	// Expected writes with the address above the data
	logic [23:0] expWrites[$];
	int writeIdx = 0;
	logic [15:0] cursor;
	int waitCnt;

	cpuCore cpuCore_i
	(
		.clock(clock),
		.arstN(arstN),
		.wbOut(wbOut),
		.wbIn(wbIn),
		.halted(halted)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////
	// Helpers

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
			abortRun($sformatf("Error at time %0t: %s is %h, expected %h",
				$time, what, got, expected));
	endtask

	function automatic logic [7:0] randByte();
		logic [31:0] r;
		r = $urandom();
		return r[7:0];
	endfunction

	task automatic putByte(input logic [7:0] v);
		mem[cursor] = v;
		cursor = cursor + 16'd1;
	endtask

	task automatic putImm(input logic [7:0] op, input logic [7:0] v);
		putByte(op);
		putByte(v);
	endtask

	task automatic putWord(input logic [7:0] op, input logic [7:0] lo, input logic [7:0] hi);
		putByte(op);
		putByte(lo);
		putByte(hi);
	endtask

	////////////////////
	// Program image

	task automatic buildImage();
		logic [15:0] loopAddr;
		logic [15:0] diff;
		logic [7:0] va;
		int loopCnt;
		// Background pattern over every address
		for (int i = 0; i < 65536; i++)
			mem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'hA5;
		cursor = 16'h0000;
		// Immediate loads and stores with post-increment
		putWord(8'h31, 8'hFE, 8'hFF);
		putWord(8'h21, randByte(), 8'hC0);
		putWord(8'h11, randByte(), 8'hD0);
		putImm(8'h3E, randByte());
		putImm(8'h06, randByte());
		putImm(8'h0E, randByte());
		putByte(8'h77);
		putByte(8'h22);
		putByte(8'h77);
		putImm(8'h3E, randByte());
		putByte(8'h22);
		// Post-decrement and loads through DE
		putByte(8'h32);
		putByte(8'h1A);
		putByte(8'h77);
		putByte(8'h13);
		putByte(8'h1A);
		putByte(8'h22);
		// Counted loop on B
		loopCnt = $urandom_range(6, 1);
		putImm(8'h06, loopCnt[7:0]);
		loopAddr = cursor;
		putByte(8'h0C);
		putByte(8'h3D);
		putByte(8'h22);
		putByte(8'h05);
		diff = loopAddr - cursor - 16'd2;
		putImm(8'h20, diff[7:0]);
		// Z forced clear so JR Z falls through
		putImm(8'h0E, 8'h10);
		putByte(8'h0C);
		putImm(8'h28, 8'h01);
		putByte(8'h22);
		// Compare equal then unequal
		va = randByte();
		putImm(8'h3E, va);
		putImm(8'hFE, va);
		putImm(8'h28, 8'h01);
		putByte(8'h22);
		putImm(8'hFE, va ^ (8'h01 | randByte()));
		putImm(8'h28, 8'h01);
		putByte(8'h22);
		// Stack traffic around a call
		putImm(8'h06, randByte());
		putImm(8'h0E, randByte());
		putByte(8'hC5);
		putWord(8'hCD, 8'h00, 8'h01);
		putByte(8'hC1);
		putByte(8'hC5);
		putImm(8'h3E, randByte());
		putByte(8'h22);
		// Unlisted opcode acts as a one-byte no-op
		putByte(8'h00);
		putByte(8'h76);
		// Subroutine clobbers B and C
		cursor = 16'h0100;
		putImm(8'h06, randByte());
		putImm(8'h0E, randByte());
		putImm(8'h3E, randByte());
		putByte(8'h22);
		putByte(8'hC9);
	endtask

	////////////////////
	// Reference model

	function automatic void noteWrite(input logic [15:0] addr, input logic [7:0] data);
		refMem[addr] = data;
		expWrites.push_back({addr, data});
	endfunction

	// Instruction-level run returning 1 on HALT
	function automatic logic modelProgram();
		logic [7:0] a, b, c, op, imm;
		logic [15:0] sp, pc, hl, de, nextPc;
		logic z;
		pc = resetPc;
		z = 1'b0;
		for (int steps = 0; steps < 5000; steps++)
		begin
			op = refMem[pc];
			imm = refMem[pc + 16'd1];
			// Instruction length
			case (op)
				8'h31, 8'h21, 8'h11, 8'hCD: nextPc = pc + 16'd3;
				8'h3E, 8'h06, 8'h0E, 8'hFE, 8'h20, 8'h28: nextPc = pc + 16'd2;
				default: nextPc = pc + 16'd1;
			endcase
			case (op)
				8'h31: sp = {refMem[pc + 16'd2], imm};
				8'h21: hl = {refMem[pc + 16'd2], imm};
				8'h11: de = {refMem[pc + 16'd2], imm};
				8'h3E: a = imm;
				8'h06: b = imm;
				8'h0E: c = imm;
				8'h32, 8'h22, 8'h77: noteWrite(hl, a);
				8'h1A: a = refMem[de];
				8'h0C: c = c + 8'd1;
				8'h23: hl = hl + 16'd1;
				8'h13: de = de + 16'd1;
				8'h3D: a = a - 8'd1;
				8'h05: b = b - 8'd1;
				8'h0D: c = c - 8'd1;
				// NZ jumps on clear Z and Z on set Z
				8'h20, 8'h28:
					if ((op == 8'h20) != z)
						nextPc = nextPc + {{8{imm[7]}}, imm};
				8'hCD:
				begin
					noteWrite(sp - 16'd1, nextPc[15:8]);
					noteWrite(sp - 16'd2, nextPc[7:0]);
					sp = sp - 16'd2;
					nextPc = {refMem[pc + 16'd2], imm};
				end
				8'hC9:
				begin
					nextPc = {refMem[sp + 16'd1], refMem[sp]};
					sp = sp + 16'd2;
				end
				8'hC5:
				begin
					noteWrite(sp - 16'd1, b);
					noteWrite(sp - 16'd2, c);
					sp = sp - 16'd2;
				end
				8'hC1:
				begin
					c = refMem[sp];
					b = refMem[sp + 16'd1];
					sp = sp + 16'd2;
				end
				8'h76: return 1'b1;
				default: ;
			endcase
			// Flag and HL side effects
			case (op)
				8'h0C, 8'h0D: z = (c == 8'h00);
				8'h05: z = (b == 8'h00);
				8'h3D: z = (a == 8'h00);
				8'hFE: z = (a == imm);
				8'h22: hl = hl + 16'd1;
				8'h32: hl = hl - 16'd1;
				default: ;
			endcase
			pc = nextPc;
		end
		return 1'b0;
	endfunction

	////////////////////
	// Wishbone slave

	// Acks after 0 to 3 wait cycles
	initial
	begin
		wbIn = '0;
		waitCnt = 0;
		forever
		begin
			@(posedge clock);
			#1;
			wbIn.ack = 1'b0;
			if (wbOut.cyc && wbOut.stb)
			begin
				if (waitCnt == 0)
				begin
					wbIn.ack = 1'b1;
					if (wbOut.we)
						mem[wbOut.adr] = wbOut.dat;
					else
						wbIn.dat = mem[wbOut.adr];
					waitCnt = $urandom_range(3, 0);
				end
				else
					waitCnt = waitCnt - 1;
			end
		end
	end

	// Acked writes against the model in order
	initial
	begin
		logic [23:0] expWord;
		forever
		begin
			@(negedge clock);
			if (wbOut.cyc && wbOut.stb && wbOut.we && wbIn.ack)
			begin
				if (writeIdx >= expWrites.size())
					abortRun("The CPU made more memory writes than the model predicts");
				else
				begin
					expWord = expWrites[writeIdx];
					checkValue({16'h0000, wbOut.adr}, {16'h0000, expWord[23:8]}, "write address");
					checkValue({24'h000000, wbOut.dat}, {24'h000000, expWord[7:0]}, "write data");
					writeIdx = writeIdx + 1;
				end
			end
		end
	end

	////////////////////
	// Main sequence

	initial
	begin
		int cycles;
		arstN = 1'b0;
		void'($urandom(32'h96d0c6e1));
		buildImage();
		for (int i = 0; i < 65536; i++)
			refMem[i[15:0]] = mem[i[15:0]];
		if (!modelProgram())
			abortRun("The reference model never reached HALT");
		repeat (3) @(posedge clock);
		#1 arstN = 1'b1;
		cycles = 0;
		while (!halted && cycles < haltTimeout)
		begin
			@(negedge clock);
			cycles = cycles + 1;
		end
		if (!halted)
			abortRun("Timeout waiting for the CPU to halt");
		// Bus must stay idle once halted
		for (cycles = 0; cycles < quietCycles; cycles++)
		begin
			@(negedge clock);
			if (wbOut.cyc || !halted)
				abortRun("The CPU left the halted state or started a bus cycle");
		end
		if (writeIdx == expWrites.size())
		begin
			$display("Regression passed");
			$finish;
		end
		else
			abortRun("The CPU halted before making all predicted memory writes");
	end

endmodule

//--- source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore
(
	input  logic clock,
	input  logic arstN,
	output cpuPkg::wbReqT wbOut,
	input  cpuPkg::wbRspT wbIn,
	output logic halted
);
	import cpuPkg::*;

	opcodeT opcode;
	logic [7:0] flowStart;
	logic [7:0] uPc;
	uopWordT uop;
	seqStateT state;
	logic execute;
	logic zFlag;
	memReqT memReq;
	logic memDone;
	logic [7:0] memData;
	logic memBusy;

	// Open request not yet answered
	assign memBusy = memReq.valid && !memDone;

	opcodeFlowLut opcodeFlowLut_i
	(
		.opcode(opcode),
		.flowStart(flowStart)
	);

	ucodeRom ucodeRom_i
	(
		.addr(uPc),
		.uop(uop)
	);

	ucodeSequencer ucodeSequencer_i
	(
		.clock(clock),
		.arstN(arstN),
		.flowStart(flowStart),
		.uop(uop),
		.zFlag(zFlag),
		.memBusy(memBusy),
		.state(state),
		.uPc(uPc),
		.execute(execute),
		.halted(halted)
	);

	cpuDatapath cpuDatapath_i
	(
		.clock(clock),
		.arstN(arstN),
		.uop(uop),
		.execute(execute),
		.state(state),
		.memReq(memReq),
		.memDone(memDone),
		.memData(memData),
		.opcode(opcode),
		.zFlag(zFlag)
	);

	wbBusMaster wbBusMaster_i
	(
		.clock(clock),
		.arstN(arstN),
		.memReq(memReq),
		.memDone(memDone),
		.memData(memData),
		.wbOut(wbOut),
		.wbIn(wbIn)
	);

endmodule

//--- source/wbBusMaster.sv
`timescale 1ns/1ps

module wbBusMaster
(
	input  logic clock,
	input  logic arstN,
	input  cpuPkg::memReqT memReq,
	output logic memDone,
	output logic [7:0] memData,
	output cpuPkg::wbReqT wbOut,
	input  cpuPkg::wbRspT wbIn
);
	typedef enum logic {busIdle, busWait} busStateT;

	busStateT busState;
	logic weQ;
	logic [15:0] adrQ;
	logic [7:0] datQ;
	logic start;
	logic finish;

	// No new cycle in the done cycle, the request is still up then
	assign start = (busState == busIdle) && memReq.valid && !memDone;
	assign finish = (busState == busWait) && wbIn.ack;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			busState <= busIdle;
			memDone <= 1'b0;
		end
		else
		begin
			memDone <= finish;
			if (start)
				busState <= busWait;
			else if (finish)
				busState <= busIdle;
		end
	end

	// Address and data held for the whole cycle
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			weQ <= memReq.write;
			adrQ <= memReq.addr;
			datQ <= memReq.data;
		end
		if (finish)
			memData <= wbIn.dat;
	end

	// cyc and stb follow the wait state
	assign wbOut = '{cyc: (busState == busWait), stb: (busState == busWait),
		we: weQ, adr: adrQ, dat: datQ};

endmodule

//--- source/cpuDatapath.sv
`timescale 1ns/1ps

module cpuDatapath
(
	input  logic clock,
	input  logic arstN,
	input  cpuPkg::uopWordT uop,
	input  logic execute,
	input  cpuPkg::seqStateT state,
	output cpuPkg::memReqT memReq,
	input  logic memDone,
	input  logic [7:0] memData,
	output cpuPkg::opcodeT opcode,
	output logic zFlag
);
	import cpuPkg::*;

	// Register file and temporaries
	logic [7:0] a, b, c, d, e, h, l, x8;
	logic [15:0] sp, pc, x16, mar;
	// Second half of a 16-bit push
	logic pushLow;
	logic [15:0] opVal;
	logic [15:0] result;
	operandT dest;
	logic memOp, step, wide, incPc, updZ;

	////////////////////
	// Operand read

	always_comb
	begin
		case (uop.sel)
			selA: opVal = {8'h00, a};
			selB: opVal = {8'h00, b};
			selC: opVal = {8'h00, c};
			selD: opVal = {8'h00, d};
			selE: opVal = {8'h00, e};
			selH: opVal = {8'h00, h};
			selL: opVal = {8'h00, l};
			selHl: opVal = {h, l};
			selDe: opVal = {d, e};
			selBc: opVal = {b, c};
			selSp: opVal = sp;
			selSpl: opVal = {8'h00, sp[7:0]};
			selSph: opVal = {8'h00, sp[15:8]};
			selPc: opVal = pc;
			selX8: opVal = {8'h00, x8};
			selX16: opVal = x16;
			default: opVal = 16'h0000;
		endcase
	end

	// Memory ops hold the step until the bus master is done
	assign memOp = execute && (uop.op == uopSrm || uop.op == uopSmw);
	assign step = execute && (!memOp || memDone);
	assign wide = (uop.op == uopSmw) && (uop.sel == selX16);
	assign incPc = uop.ctl inside {ctlInc, ctlIncEof, ctlIncEofZ, ctlIncEofNz, ctlIncEofFu};
	assign updZ = uop.ctl inside {ctlEofFu, ctlIncEofFu};

	// Destination and value of the operation
	always_comb
	begin
		dest = selNone;
		result = opVal;
		case (uop.op)
			uopSrm:
			begin
				dest = uop.sel;
				// x16 fills from the top, low byte first
				result = (uop.sel == selX16) ? {memData, x16[15:8]} : {8'h00, memData};
			end
			uopInc16:
			begin
				dest = uop.sel;
				result = opVal + 16'd1;
			end
			uopDec16:
			begin
				dest = uop.sel;
				result = opVal - 16'd1;
			end
			uopSrx16:
			begin
				dest = uop.sel;
				result = x16;
			end
			uopSx16r:
				dest = selX16;
			uopAddx16:
			begin
				dest = selX16;
				result = x16 + {{8{opVal[7]}}, opVal[7:0]};
			end
			uopSubx16:
			begin
				dest = selX16;
				result = x16 - opVal;
			end
			uopSpc:
				dest = selPc;
			default:
				dest = selNone;
		endcase
	end

	////////////////////
	// Memory request

	always_comb
	begin
		memReq.valid = (state == stFetch) || memOp;
		memReq.write = memOp && (uop.op == uopSmw);
		if (state == stFetch)
			memReq.addr = pc;
		else if (wide)
			memReq.addr = pushLow ? sp : sp + 16'd1;
		else
			memReq.addr = mar;
		if (wide)
			memReq.data = pushLow ? x16[7:0] : x16[15:8];
		else
			memReq.data = opVal[7:0];
	end

	// Program counter, flag and push phase
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= resetPc;
			zFlag <= 1'b0;
			pushLow <= 1'b0;
		end
		else if (step)
		begin
			if (incPc)
				pc <= pc + 16'd1;
			// A jump overrides the increment
			if (dest == selPc)
				pc <= result;
			if (updZ)
				zFlag <= (result[7:0] == 8'h00);
			if (wide)
				pushLow <= !pushLow;
		end
	end

	// Registers and temporaries
	always_ff @(posedge clock)
	begin
		if (state == stFetch && memDone)
			opcode <= opcodeT'(memData);
		if (step)
		begin
			if (uop.op == uopSma)
				mar <= opVal;
			case (dest)
				selA: a <= result[7:0];
				selB: b <= result[7:0];
				selC: c <= result[7:0];
				selD: d <= result[7:0];
				selE: e <= result[7:0];
				selH: h <= result[7:0];
				selL: l <= result[7:0];
				selHl: {h, l} <= result;
				selDe: {d, e} <= result;
				selBc: {b, c} <= result;
				selSp: sp <= result;
				selSpl: sp[7:0] <= result[7:0];
				selSph: sp[15:8] <= result[7:0];
				selX8: x8 <= result[7:0];
				selX16: x16 <= result;
				default: ;
			endcase
		end
	end

endmodule

//--- source/ucodeSequencer.sv
`timescale 1ns/1ps

module ucodeSequencer
(
	input  logic clock,
	input  logic arstN,
	input  logic [7:0] flowStart,
	input  cpuPkg::uopWordT uop,
	input  logic zFlag,
	input  logic memBusy,
	output cpuPkg::seqStateT state,
	output logic [7:0] uPc,
	output logic execute,
	output logic halted
);
	import cpuPkg::*;

	logic endFlow;

	// Plain eof codes always end, Z codes only on their condition
	always_comb
	begin
		case (uop.ctl)
			ctlEof, ctlIncEof, ctlEofFu, ctlIncEofFu: endFlow = 1'b1;
			ctlIncEofZ: endFlow = zFlag;
			ctlIncEofNz: endFlow = !zFlag;
			default: endFlow = 1'b0;
		endcase
	end

	assign execute = (state == stExecute);
	assign halted = (state == stHalted);

	////////////////////
	// Fetch, decode, execute

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stFetch;
			uPc <= nopFlow;
		end
		else
		begin
			case (state)
				// Opcode read in flight
				stFetch:
					if (!memBusy)
						state <= stDecode;
				// Jump to the flow entry
				stDecode:
				begin
					uPc <= flowStart;
					state <= stExecute;
				end
				stExecute:
					if (uop.op == uopHalt)
						state <= stHalted;
					else if (!memBusy)
					begin
						if (endFlow)
							state <= stFetch;
						else
							uPc <= uPc + 8'd1;
					end
				// Only reset leaves here
				default:
					state <= stHalted;
			endcase
		end
	end

endmodule

//--- source/ucodeRom.sv
`timescale 1ns/1ps

module ucodeRom
(
	input  logic [7:0] addr,
	output cpuPkg::uopWordT uop
);
	import cpuPkg::*;

	// Every flow starts with pc on the opcode byte
	always_comb
	begin
		case (addr)
			// No operation
			0: uop = '{ctlIncEof, uopNop, selNone};
			// LD SP,nn
			1: uop = '{ctlInc, uopNop, selNone};
			2: uop = '{ctlOp, uopSma, selPc};
			3: uop = '{ctlInc, uopSrm, selSpl};
			4: uop = '{ctlOp, uopSma, selPc};
			5: uop = '{ctlIncEof, uopSrm, selSph};
			// LD HL,nn
			6: uop = '{ctlInc, uopNop, selNone};
			7: uop = '{ctlOp, uopSma, selPc};
			8: uop = '{ctlInc, uopSrm, selL};
			9: uop = '{ctlOp, uopSma, selPc};
			10: uop = '{ctlIncEof, uopSrm, selH};
			// LD DE,nn
			11: uop = '{ctlInc, uopNop, selNone};
			12: uop = '{ctlOp, uopSma, selPc};
			13: uop = '{ctlInc, uopSrm, selE};
			14: uop = '{ctlOp, uopSma, selPc};
			15: uop = '{ctlIncEof, uopSrm, selD};
			// LD A,n then B,n then C,n
			16: uop = '{ctlInc, uopNop, selNone};
			17: uop = '{ctlOp, uopSma, selPc};
			18: uop = '{ctlIncEof, uopSrm, selA};
			19: uop = '{ctlInc, uopNop, selNone};
			20: uop = '{ctlOp, uopSma, selPc};
			21: uop = '{ctlIncEof, uopSrm, selB};
			22: uop = '{ctlInc, uopNop, selNone};
			23: uop = '{ctlOp, uopSma, selPc};
			24: uop = '{ctlIncEof, uopSrm, selC};
			// LD (HL-),A
			25: uop = '{ctlOp, uopSma, selHl};
			26: uop = '{ctlOp, uopSmw, selA};
			27: uop = '{ctlIncEof, uopDec16, selHl};
			// LD (HL+),A
			28: uop = '{ctlOp, uopSma, selHl};
			29: uop = '{ctlOp, uopSmw, selA};
			30: uop = '{ctlIncEof, uopInc16, selHl};
			// LD (HL),A
			31: uop = '{ctlOp, uopSma, selHl};
			32: uop = '{ctlIncEof, uopSmw, selA};
			// LD A,(DE)
			33: uop = '{ctlOp, uopSma, selDe};
			34: uop = '{ctlIncEof, uopSrm, selA};
			// Single-step increments and decrements
			35: uop = '{ctlIncEofFu, uopInc16, selC};
			36: uop = '{ctlIncEof, uopInc16, selHl};
			37: uop = '{ctlIncEof, uopInc16, selDe};
			38: uop = '{ctlIncEofFu, uopDec16, selA};
			39: uop = '{ctlIncEofFu, uopDec16, selB};
			40: uop = '{ctlIncEofFu, uopDec16, selC};
			// CP n, compare through x16
			41: uop = '{ctlInc, uopSx16r, selA};
			42: uop = '{ctlOp, uopSma, selPc};
			43: uop = '{ctlInc, uopSrm, selX8};
			44: uop = '{ctlEofFu, uopSubx16, selX8};
			// JR NZ,n
			45: uop = '{ctlInc, uopNop, selNone};
			46: uop = '{ctlOp, uopSma, selPc};
			47: uop = '{ctlIncEofZ, uopSrm, selX8};   // leave when Z set
			48: uop = '{ctlOp, uopSx16r, selPc};
			49: uop = '{ctlOp, uopAddx16, selX8};
			50: uop = '{ctlEof, uopSpc, selX16};
			// JR Z,n
			51: uop = '{ctlInc, uopNop, selNone};
			52: uop = '{ctlOp, uopSma, selPc};
			53: uop = '{ctlIncEofNz, uopSrm, selX8};  // leave when Z clear
			54: uop = '{ctlOp, uopSx16r, selPc};
			55: uop = '{ctlOp, uopAddx16, selX8};
			56: uop = '{ctlEof, uopSpc, selX16};
			// CALL nn
			// Return address op+3 built in x16
			57: uop = '{ctlInc, uopSx16r, selPc};
			58: uop = '{ctlOp, uopInc16, selX16};
			59: uop = '{ctlOp, uopInc16, selX16};
			60: uop = '{ctlOp, uopInc16, selX16};
			61: uop = '{ctlOp, uopDec16, selSp};
			62: uop = '{ctlOp, uopDec16, selSp};
			// High byte to sp+1, then low byte to sp
			63: uop = '{ctlOp, uopSmw, selX16};
			64: uop = '{ctlOp, uopSmw, selX16};
			// Target shifted into x16, low byte first
			65: uop = '{ctlOp, uopSma, selPc};
			66: uop = '{ctlInc, uopSrm, selX16};
			67: uop = '{ctlOp, uopSma, selPc};
			68: uop = '{ctlOp, uopSrm, selX16};
			69: uop = '{ctlEof, uopSpc, selX16};
			// RET
			70: uop = '{ctlOp, uopSma, selSp};
			71: uop = '{ctlOp, uopSrm, selX16};
			72: uop = '{ctlOp, uopInc16, selSp};
			73: uop = '{ctlOp, uopSma, selSp};
			74: uop = '{ctlOp, uopSrm, selX16};
			75: uop = '{ctlOp, uopInc16, selSp};
			76: uop = '{ctlEof, uopSpc, selX16};
			// PUSH BC
			77: uop = '{ctlOp, uopDec16, selSp};
			78: uop = '{ctlOp, uopSma, selSp};
			79: uop = '{ctlOp, uopSmw, selB};
			80: uop = '{ctlOp, uopDec16, selSp};
			81: uop = '{ctlOp, uopSma, selSp};
			82: uop = '{ctlIncEof, uopSmw, selC};
			// POP BC
			83: uop = '{ctlOp, uopSma, selSp};
			84: uop = '{ctlOp, uopSrm, selC};
			85: uop = '{ctlOp, uopInc16, selSp};
			86: uop = '{ctlOp, uopSma, selSp};
			87: uop = '{ctlOp, uopSrm, selB};
			88: uop = '{ctlIncEof, uopInc16, selSp};
			// HALT
			89: uop = '{ctlEof, uopHalt, selNone};
			// Unused space falls back to fetch
			default: uop = '{ctlEof, uopNop, selNone};
		endcase
	end

endmodule

//--- source/opcodeFlowLut.sv
`timescale 1ns/1ps

module opcodeFlowLut
(
	input  cpuPkg::opcodeT opcode,
	output logic [7:0] flowStart
);
	import cpuPkg::*;

	// Entry points must track the ROM layout
	always_comb
	begin
		case (opcode)
			opLdSpNn: flowStart = 8'd1;
			opLdHlNn: flowStart = 8'd6;
			opLdDeNn: flowStart = 8'd11;
			opLdAN: flowStart = 8'd16;
			opLdBN: flowStart = 8'd19;
			opLdCN: flowStart = 8'd22;
			opLdHldA: flowStart = 8'd25;
			opLdHliA: flowStart = 8'd28;
			opLdHlA: flowStart = 8'd31;
			opLdADe: flowStart = 8'd33;
			opIncC: flowStart = 8'd35;
			opIncHl: flowStart = 8'd36;
			opIncDe: flowStart = 8'd37;
			opDecA: flowStart = 8'd38;
			opDecB: flowStart = 8'd39;
			opDecC: flowStart = 8'd40;
			opCpN: flowStart = 8'd41;
			opJrNz: flowStart = 8'd45;
			opJrZ: flowStart = 8'd51;
			opCallNn: flowStart = 8'd57;
			opRet: flowStart = 8'd70;
			opPushBc: flowStart = 8'd77;
			opPopBc: flowStart = 8'd83;
			opHalt: flowStart = 8'd89;
			// Anything else just skips one byte
			default: flowStart = nopFlow;
		endcase
	end

endmodule

//--- source/cpuPkg.sv
package cpuPkg;

	////////////////////
	// Constants

	// Program counter after reset
	localparam logic [15:0] resetPc = 16'h0000;
	// Single-entry no-operation flow
	localparam logic [7:0] nopFlow = 8'd0;

	////////////////////
	// Encodings

	// Supported opcode bytes
	typedef enum logic [7:0] {
		opLdSpNn = 8'h31, opLdHlNn = 8'h21, opLdDeNn = 8'h11, opLdAN = 8'h3E,
		opLdBN = 8'h06, opLdCN = 8'h0E, opLdHldA = 8'h32, opLdHliA = 8'h22,
		opLdHlA = 8'h77, opLdADe = 8'h1A, opIncC = 8'h0C, opIncHl = 8'h23,
		opIncDe = 8'h13, opDecA = 8'h3D, opDecB = 8'h05, opDecC = 8'h0D,
		opCpN = 8'hFE, opJrNz = 8'h20, opJrZ = 8'h28, opCallNn = 8'hCD,
		opRet = 8'hC9, opPushBc = 8'hC5, opPopBc = 8'hC1, opHalt = 8'h76
	} opcodeT;

	// Flow control field
	// Inc bumps pc, Eof ends the flow, Z/Nz end early on the flag, Fu updates Z
	typedef enum logic [2:0] {
		ctlOp, ctlInc, ctlEof, ctlIncEof, ctlIncEofZ, ctlIncEofNz, ctlEofFu, ctlIncEofFu
	} flowCtlT;

	// Operation field
	typedef enum logic [3:0] {
		uopNop, uopSma, uopSrm, uopSmw, uopInc16, uopDec16, uopSx16r, uopSrx16,
		uopAddx16, uopSubx16, uopSpc, uopHalt
	} uopOpT;

	// Operand field
	typedef enum logic [4:0] {
		selA, selB, selC, selD, selE, selH, selL, selHl, selDe, selBc, selSp,
		selSpl, selSph, selPc, selX8, selX16, selNone
	} operandT;

	// One microinstruction
	typedef struct packed {
		flowCtlT ctl;
		uopOpT op;
		operandT sel;
	} uopWordT;

	////////////////////
	// Bus bundles

	// Wishbone classic, master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [15:0] adr;
		logic [7:0] dat;
	} wbReqT;

	// Wishbone classic, slave side
	typedef struct packed {
		logic ack;
		logic [7:0] dat;
	} wbRspT;

	// Datapath to bus master
	typedef struct packed {
		logic valid;
		logic write;
		logic [15:0] addr;
		logic [7:0] data;
	} memReqT;

	// Sequencer states
	typedef enum logic [1:0] {stFetch, stDecode, stExecute, stHalted} seqStateT;

endpackage
